// File: list.f
design/fetch_pkg.sv
design/fetch_predecode.sv
design/fetch_mini_cache.sv
design/fetch_pc_ctrl.sv
design/fetch_decode_reg.sv
design/fetch_unit.sv
tb/fetch_assert.sv
tb/fetch_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module fetch_tb -f list.f -o fetch_sim
./obj_dir/fetch_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "^TEST PASS$" sim.log
then
   exit 0
else
   echo "simulation did not pass"
   exit 1
fi

// File: tb/fetch_tb.sv
// testbench for the fetch unit, drives a memory bus model and checks the decode stream
`timescale 1ns/1ns

module fetch_tb;

   localparam int MEM_WORDS      = 1024;
   localparam int NUM_TESTS      = 7;
   localparam int TIMEOUT_CYCLES = 400 * NUM_TESTS;
   localparam logic [31:0] SEED  = 32'd69243;
   localparam logic [5:0] OPC_ALU = 6'h38;

   logic        clk = 1'b0;
   logic        rst = 1'b1;
   logic        ibus_req;
   logic [31:0] ibus_adr;
   logic        ibus_ack = 1'b0;
   logic        ibus_err = 1'b0;
   logic [31:0] ibus_dat = '0;
   logic        padv = 1'b1;
   logic        flag = 1'b0;
   logic        except = 1'b0;
   logic [31:0] branch_dest = '0;
   logic [15:0] spr_addr = '0;
   logic        spr_we = 1'b0;
   logic        spr_stb = 1'b0;
   logic        spr_ack;
   logic [31:0] decode_insn;
   logic [31:0] fetched_pc;
   logic        ibus_err_flag;
   logic [4:0]  rfa_adr;
   logic [4:0]  rfb_adr;
   logic        rf_re;
   logic        sleep;

   // memory model state
   logic [31:0] mem [0:MEM_WORDS-1];
   logic [31:0] err_adr = 32'hffff_ffff;
   logic [31:0] adr_seen = '0;
   logic        req_seen = 1'b0;
   logic [10:0] rf_seen = '0;
   logic        pending = 1'b0;
   int          wait_left = 0;
   int          total_reqs = 0;
   int unsigned reqs [logic [31:0]];
   logic [31:0] bus_lfsr = SEED;
   logic [31:0] padv_lfsr = SEED;

   // decode stream and its model
   logic [31:0] got_insn[$];
   logic [31:0] got_pc[$];
   logic [10:0] got_rf[$];
   logic [31:0] exp_insn[$];
   logic [31:0] exp_pc[$];

   int errors = 0;
   int checks = 0;
   int err_base = 0;
   int cycles = 0;

   fetch_unit UUT
   (
      .clk                           (clk),
      .rst                           (rst),
      .ibus_req_o                    (ibus_req),
      .ibus_adr_o                    (ibus_adr),
      .ibus_ack_i                    (ibus_ack),
      .ibus_err_i                    (ibus_err),
      .ibus_dat_i                    (ibus_dat),
      .padv_i                        (padv),
      .flag_i                        (flag),
      .flag_set_i                    (1'b0),
      .flag_clear_i                  (1'b0),
      .fetch_take_exception_branch_i (except),
      .branch_dest_i                 (branch_dest),
      .spr_bus_addr_i                (spr_addr),
      .spr_bus_we_i                  (spr_we),
      .spr_bus_stb_i                 (spr_stb),
      .spr_bus_ack_ic_o              (spr_ack),
      .decode_insn_o                 (decode_insn),
      .fetched_pc_o                  (fetched_pc),
      .decode_except_ibus_err_o      (ibus_err_flag),
      .fetch_rfa_adr_o               (rfa_adr),
      .fetch_rfb_adr_o               (rfb_adr),
      .fetch_rf_re_o                 (rf_re),
      .fetch_sleep_o                 (sleep)
   );

   always #4 clk = ~clk;

   // galois lfsr, the new lsb is the bit that is taken
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic lsb;
      lsb = s[0];
      s = s >> 1;
      if (lsb)
         s = s ^ 32'ha300_0000;
      return s;
   endfunction

   function automatic logic [31:0] enc(input logic [5:0] opc, input logic [25:0] off);
      return {opc, off};
   endfunction

   function automatic int req_count(input logic [31:0] a);
      return reqs.exists(a) ? int'(reqs[a]) : 0;
   endfunction

   // jumps and branches carry an offset and read no registers
   function automatic logic reads_regs(input logic [31:0] w);
      logic [5:0] opc;
      opc = w[31:26];
      return !(opc == fetch_pkg::OPC_J || opc == fetch_pkg::OPC_JAL ||
               opc == fetch_pkg::OPC_BF || opc == fetch_pkg::OPC_BNF);
   endfunction

   // request and regfile read ports seen in the cycle that just ended
   always @(posedge clk)
   begin
      req_seen <= ibus_req & ~rst;
      adr_seen <= ibus_adr;
      rf_seen  <= {rfa_adr, rfb_adr, rf_re};
   end

   // bus model, answers one to three cycles after it sees a request
   always @(negedge clk)
   begin
      if (ibus_ack || ibus_err)
      begin
         ibus_ack = 1'b0;
         ibus_err = 1'b0;
         pending = 1'b0;
      end
      else if (!req_seen)
         pending = 1'b0;
      else
      begin
         if (!pending)
         begin
            pending = 1'b1;
            total_reqs++;
            reqs[adr_seen] = reqs.exists(adr_seen) ? reqs[adr_seen] + 1 : 1;
            bus_lfsr = lfsr_step(bus_lfsr);
            wait_left = int'(bus_lfsr[0]);
            bus_lfsr = lfsr_step(bus_lfsr);
            // two bits give 0..3, capped at 2 extra cycles
            wait_left = (wait_left == 1 && bus_lfsr[0]) ? 2 :
                        wait_left + 2 * int'(bus_lfsr[0]);
         end
         else
            wait_left--;
         if (wait_left == 0)
         begin
            if (adr_seen == err_adr)
               ibus_err = 1'b1;
            else
            begin
               ibus_ack = 1'b1;
               ibus_dat = mem[adr_seen[11:2]];
            end
         end
      end
   end

   // run limit
   always @(posedge clk)
   begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES)
      begin
         $display("timeout after %0d cycles, a test never completed", cycles);
         $display("TEST FAIL");
         $finish;
      end
   end

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         $display("FAIL %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   // walks the program from start, taking early branches by the flag
   task automatic build_expected(input logic [31:0] start, input int n, input logic f);
      logic [31:0] pc;
      logic [31:0] w;
      logic [31:0] tgt;
      logic [5:0]  opc;
      pc = start;
      exp_insn.delete();
      exp_pc.delete();
      for (int i = 0; i < n; i++)
      begin
         w = mem[pc[11:2]];
         opc = w[31:26];
         exp_insn.push_back(w);
         exp_pc.push_back(pc);
         if (opc == fetch_pkg::OPC_J || opc == fetch_pkg::OPC_JAL ||
             (opc == fetch_pkg::OPC_BF && f) || (opc == fetch_pkg::OPC_BNF && !f))
         begin
            tgt = pc + {{4{w[25]}}, w[25:0], 2'b00};
            // jump to self ends the stream
            if (tgt == pc)
               break;
            pc = tgt;
         end
         else
            pc = pc + 32'd4;
      end
   endtask

   // gathers loaded non bubble words, padv optionally random
   task automatic collect(input int n, input logic rand_padv);
      got_insn.delete();
      got_pc.delete();
      got_rf.delete();
      while (got_insn.size() < n)
      begin
         @(negedge clk);
         if (padv && decode_insn != fetch_pkg::NOP_INSN)
         begin
            got_insn.push_back(decode_insn);
            got_pc.push_back(fetched_pc);
            got_rf.push_back(rf_seen);
         end
         padv = 1'b1;
         if (rand_padv)
         begin
            padv_lfsr = lfsr_step(padv_lfsr);
            if (padv_lfsr[0])
            begin
               padv_lfsr = lfsr_step(padv_lfsr);
               padv = ~padv_lfsr[0];
            end
         end
      end
      padv = 1'b1;
   endtask

   // regfile fields are ra in bits 20..16 and rb in bits 15..11
   task automatic compare_stream();
      for (int i = 0; i < exp_insn.size(); i++)
      begin
         check_val("decode_insn_o", got_insn[i], exp_insn[i]);
         check_val("fetched_pc_o", got_pc[i], exp_pc[i]);
         check_val("fetch_rfa_adr_o", 32'(got_rf[i][10:6]), 32'(exp_insn[i][20:16]));
         check_val("fetch_rfb_adr_o", 32'(got_rf[i][5:1]), 32'(exp_insn[i][15:11]));
         check_val("fetch_rf_re_o", 32'(got_rf[i][0]), 32'(reads_regs(exp_insn[i])));
      end
   endtask

   task automatic redirect(input logic [31:0] dest);
      @(negedge clk);
      except = 1'b1;
      branch_dest = dest;
      @(negedge clk);
      except = 1'b0;
   endtask

   task automatic end_test(input string name);
      $display("%s done, %0d errors", name, errors - err_base);
      err_base = errors;
   endtask

   task automatic test_reset();
      check_val("decode_insn_o", decode_insn, fetch_pkg::NOP_INSN);
      check_val("ibus_adr_o", ibus_adr, fetch_pkg::RESET_PC);
      check_val("ibus_req_o", 32'(ibus_req), 32'd1);
      check_val("fetch_sleep_o", 32'(sleep), 32'd0);
      check_val("decode_except_ibus_err_o", 32'(ibus_err_flag), 32'd0);
      end_test("reset");
   endtask

   task automatic test_sequential();
      redirect(32'h800);
      build_expected(32'h800, 24, 1'b0);
      collect(24, 1'b1);
      compare_stream();
      end_test("sequential");
   endtask

   task automatic test_branch(input logic f);
      flag = f;
      redirect(32'h200);
      build_expected(32'h200, 8, f);
      collect(8, 1'b0);
      compare_stream();
      end_test(f ? "branch flag set" : "branch flag clear");
   endtask

   task automatic test_sleep();
      int snap;
      redirect(32'h600);
      build_expected(32'h600, 4, 1'b0);
      collect(exp_insn.size(), 1'b0);
      compare_stream();
      repeat (3) @(negedge clk);
      check_val("fetch_sleep_o", 32'(sleep), 32'd1);
      snap = total_reqs;
      repeat (10) @(negedge clk);
      check_val("request count in sleep", total_reqs, snap);
      check_val("decode_insn_o", decode_insn, fetch_pkg::NOP_INSN);
      redirect(32'h700);
      check_val("fetch_sleep_o", 32'(sleep), 32'd0);
      build_expected(32'h700, 3, 1'b0);
      collect(3, 1'b0);
      compare_stream();
      end_test("sleep");
   endtask

   task automatic test_cache();
      reqs.delete();
      redirect(32'h400);
      build_expected(32'h400, 12, 1'b0);
      collect(12, 1'b0);
      compare_stream();
      for (int a = 32'h400; a < 32'h410; a += 4)
         check_val("bus requests per loop word", req_count(a), 1);
      check_val("fall through requests", req_count(32'h410), 0);
      @(negedge clk);
      spr_addr = fetch_pkg::SPR_ICBIR;
      spr_we = 1'b1;
      spr_stb = 1'b1;
      @(negedge clk);
      spr_stb = 1'b0;
      spr_we = 1'b0;
      check_val("spr_bus_ack_ic_o", 32'(spr_ack), 32'd1);
      collect(8, 1'b0);
      for (int a = 32'h400; a < 32'h410; a += 4)
         check_val("bus requests after invalidate", req_count(a), 2);
      end_test("mini cache");
   endtask

   task automatic test_bus_error();
      int snap;
      int n;
      err_adr = 32'h90c;
      redirect(32'h900);
      build_expected(32'h900, 3, 1'b0);
      collect(3, 1'b0);
      compare_stream();
      n = 0;
      while (!ibus_err_flag && n < 50)
      begin
         @(negedge clk);
         n++;
      end
      if (!ibus_err_flag)
      begin
         $display("bus error flag never rose after the error response");
         errors++;
      end
      snap = total_reqs;
      repeat (10) @(negedge clk);
      check_val("request count after bus error", total_reqs, snap);
      redirect(32'h100);
      err_adr = 32'hffff_ffff;
      check_val("decode_except_ibus_err_o", 32'(ibus_err_flag), 32'd0);
      // fetching resumes at the exception target
      build_expected(32'h100, 2, 1'b0);
      collect(2, 1'b0);
      compare_stream();
      end_test("bus error");
   endtask

   initial
   begin
      // alu words, register fields vary with the address
      for (int i = 0; i < MEM_WORDS; i++)
         mem[i] = {OPC_ALU, 5'(i), 5'(i >> 5), 5'(~i), 11'(i)};
      // branch program
      mem[32'h204 >> 2] = enc(fetch_pkg::OPC_BF, 26'd4);
      mem[32'h218 >> 2] = enc(fetch_pkg::OPC_BNF, 26'd3);
      mem[32'h220 >> 2] = enc(fetch_pkg::OPC_J, 26'd8);
      // loop for the cache test
      mem[32'h40c >> 2] = enc(fetch_pkg::OPC_J, 26'h3ff_fffd);
      // jump to self
      mem[32'h604 >> 2] = enc(fetch_pkg::OPC_JAL, 26'd0);
      repeat (10) @(negedge clk);
      rst = 1'b0;
      test_reset();
      test_sequential();
      test_branch(1'b1);
      test_branch(1'b0);
      test_sleep();
      test_cache();
      test_bus_error();
      errors += UUT.u_assert.fail_cnt;
      $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
      if (errors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

// File: tb/fetch_assert.sv
// bus and sleep protocol assertions for the fetch unit
`timescale 1ns/1ns

module fetch_assert
(
   input logic        clk,
   input logic        rst,
   input logic        req_i,
   input logic        ack_i,
   input logic        err_i,
   input logic [31:0] adr_i,
   input logic        sleep_i,
   input logic [31:0] decode_insn_i
);

   int fail_cnt = 0;

   // address holds while a request waits for its answer
   adr_stable: assert property (@(posedge clk) disable iff (rst)
      req_i && !ack_i && !err_i |=> $stable(adr_i))
      else begin fail_cnt++; $error("bus address moved under a waiting request"); end

   no_req_in_sleep: assert property (@(posedge clk) disable iff (rst)
      sleep_i |-> !req_i)
      else begin fail_cnt++; $error("bus request while asleep"); end

   // the jump to self word itself loads on the edge that sets sleep
   bubble_in_sleep: assert property (@(posedge clk) disable iff (rst)
      sleep_i && $past(sleep_i) |-> decode_insn_i == fetch_pkg::NOP_INSN)
      else begin fail_cnt++; $error("decode word is not a bubble while asleep"); end

endmodule

bind fetch_unit fetch_assert u_assert
(
   .clk           (clk),
   .rst           (rst),
   .req_i         (ibus_req_o),
   .ack_i         (ibus_ack_i),
   .err_i         (ibus_err_i),
   .adr_i         (ibus_adr_o),
   .sleep_i       (fetch_sleep_o),
   .decode_insn_i (decode_insn_o)
);

// File: design/fetch_unit.sv
// fetch unit top, connects predecode, mini cache, pc control and decode register
`timescale 1ns/1ns

module fetch_unit
(
   input  logic                             clk,
   input  logic                             rst,
   // instruction bus
   output logic                             ibus_req_o,
   output logic [fetch_pkg::ADDR_W-1:0]     ibus_adr_o,
   input  logic                             ibus_ack_i,
   input  logic                             ibus_err_i,
   input  logic [fetch_pkg::INSN_W-1:0]     ibus_dat_i,
   // pipeline control
   input  logic                             padv_i,
   input  logic                             flag_i,
   input  logic                             flag_set_i,
   input  logic                             flag_clear_i,
   input  logic                             fetch_take_exception_branch_i,
   input  logic [fetch_pkg::ADDR_W-1:0]     branch_dest_i,
   // spr bus
   input  logic [fetch_pkg::SPR_ADDR_W-1:0] spr_bus_addr_i,
   input  logic                             spr_bus_we_i,
   input  logic                             spr_bus_stb_i,
   output logic                             spr_bus_ack_ic_o,
   // to decode and the register file
   output logic [fetch_pkg::INSN_W-1:0]     decode_insn_o,
   output logic [fetch_pkg::ADDR_W-1:0]     fetched_pc_o,
   output logic                             decode_except_ibus_err_o,
   output logic [fetch_pkg::RF_ADDR_W-1:0]  fetch_rfa_adr_o,
   output logic [fetch_pkg::RF_ADDR_W-1:0]  fetch_rfb_adr_o,
   output logic                             fetch_rf_re_o,
   output logic                             fetch_sleep_o
);

   logic [fetch_pkg::ADDR_W-1:0] pc;
   logic [fetch_pkg::ADDR_W-1:0] early_pc;
   logic [fetch_pkg::INSN_W-1:0] cache_insn;
   logic [fetch_pkg::INSN_W-1:0] new_insn;
   logic                         cache_hit;
   logic                         insn_ready;
   logic                         cache_fill;
   logic                         take_early;
   logic                         will_branch;
   logic                         no_rf_read;
   logic                         to_self;

   // word source, cache on a hit, else the bus in its ack cycle
   assign new_insn   = cache_hit ? cache_insn : ibus_dat_i;
   assign insn_ready = cache_hit | ibus_ack_i;

   // a jump to self is kept out so a wake up refetches it from the bus
   assign cache_fill = ibus_ack_i & ~ibus_err_i & ~to_self;

   assign ibus_adr_o = pc;

   fetch_predecode u_predecode
   (
      .new_insn_i    (new_insn),
      .insn_ready_i  (insn_ready),
      .pc_i          (pc),
      .flag_i        (flag_i),
      .flag_set_i    (flag_set_i),
      .flag_clear_i  (flag_clear_i),
      .take_early_o  (take_early),
      .early_pc_o    (early_pc),
      .will_branch_o (will_branch),
      .no_rf_read_o  (no_rf_read),
      .to_self_o     (to_self)
   );

   fetch_mini_cache u_mini_cache
   (
      .clk        (clk),
      .rst        (rst),
      .pc_i       (pc),
      .fill_i     (cache_fill),
      .fill_dat_i (ibus_dat_i),
      .spr_addr_i (spr_bus_addr_i),
      .spr_we_i   (spr_bus_we_i),
      .spr_stb_i  (spr_bus_stb_i),
      .hit_o      (cache_hit),
      .insn_o     (cache_insn),
      .spr_ack_o  (spr_bus_ack_ic_o)
   );

   fetch_pc_ctrl u_pc_ctrl
   (
      .clk           (clk),
      .rst           (rst),
      .padv_i        (padv_i),
      .insn_ready_i  (insn_ready),
      .cache_hit_i   (cache_hit),
      .ibus_err_i    (ibus_err_i),
      .take_early_i  (take_early),
      .early_pc_i    (early_pc),
      .will_branch_i (will_branch),
      .to_self_i     (to_self),
      .except_i      (fetch_take_exception_branch_i),
      .except_pc_i   (branch_dest_i),
      .pc_o          (pc),
      .ibus_req_o    (ibus_req_o),
      .sleep_o       (fetch_sleep_o)
   );

   fetch_decode_reg u_decode_reg
   (
      .clk               (clk),
      .rst               (rst),
      .padv_i            (padv_i),
      .insn_ready_i      (insn_ready),
      .new_insn_i        (new_insn),
      .pc_i              (pc),
      .no_rf_read_i      (no_rf_read),
      .sleep_i           (fetch_sleep_o),
      .except_i          (fetch_take_exception_branch_i),
      .ibus_err_i        (ibus_err_i),
      .req_i             (ibus_req_o),
      .decode_insn_o     (decode_insn_o),
      .fetched_pc_o      (fetched_pc_o),
      .except_ibus_err_o (decode_except_ibus_err_o),
      .rfa_adr_o         (fetch_rfa_adr_o),
      .rfb_adr_o         (fetch_rfb_adr_o),
      .rf_re_o           (fetch_rf_re_o)
   );

endmodule

// File: design/fetch_decode_reg.sv
// fetch to decode register with fetched pc, bus error flag and regfile read ports
`timescale 1ns/1ns

module fetch_decode_reg
(
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            padv_i,
   input  logic                            insn_ready_i,
   input  logic [fetch_pkg::INSN_W-1:0]    new_insn_i,
   input  logic [fetch_pkg::ADDR_W-1:0]    pc_i,
   input  logic                            no_rf_read_i,
   input  logic                            sleep_i,
   input  logic                            except_i,
   input  logic                            ibus_err_i,
   input  logic                            req_i,
   output logic [fetch_pkg::INSN_W-1:0]    decode_insn_o,
   output logic [fetch_pkg::ADDR_W-1:0]    fetched_pc_o,
   output logic                            except_ibus_err_o,
   output logic [fetch_pkg::RF_ADDR_W-1:0] rfa_adr_o,
   output logic [fetch_pkg::RF_ADDR_W-1:0] rfb_adr_o,
   output logic                            rf_re_o
);

   logic accept_w;

   assign accept_w = insn_ready_i & padv_i & ~sleep_i & ~except_i;

   // decode word
   // bubble when advancing with nothing ready, hold while padv is low
   always_ff @(posedge clk)
   begin
      if (rst)
         decode_insn_o <= fetch_pkg::NOP_INSN;
      else if (except_i | sleep_i)
         decode_insn_o <= fetch_pkg::NOP_INSN;
      else if (padv_i)
         decode_insn_o <= insn_ready_i ? new_insn_i : fetch_pkg::NOP_INSN;
   end

   // pc of the word now in decode
   always_ff @(posedge clk)
   begin
      if (accept_w)
         fetched_pc_o <= pc_i;
   end

   // bus error flag, sampled only while a request is on the bus
   always_ff @(posedge clk)
   begin
      if (rst)
         except_ibus_err_o <= 1'b0;
      else if (except_i)
         except_ibus_err_o <= 1'b0;
      else if (req_i)
         except_ibus_err_o <= ibus_err_i;
   end

   // regfile read runs alongside the load into decode
   assign rfa_adr_o = insn_ready_i ? new_insn_i[fetch_pkg::RFA_LSB +: fetch_pkg::RF_ADDR_W] : '0;
   assign rfb_adr_o = insn_ready_i ? new_insn_i[fetch_pkg::RFB_LSB +: fetch_pkg::RF_ADDR_W] : '0;
   assign rf_re_o   = accept_w & ~no_rf_read_i;

endmodule

// File: design/fetch_pc_ctrl.sv
// fetch pc control, holds the program counter, the bus request state and sleep
`timescale 1ns/1ns

module fetch_pc_ctrl
(
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         padv_i,
   input  logic                         insn_ready_i,
   input  logic                         cache_hit_i,
   input  logic                         ibus_err_i,
   input  logic                         take_early_i,
   input  logic [fetch_pkg::ADDR_W-1:0] early_pc_i,
   input  logic                         will_branch_i,
   input  logic                         to_self_i,
   input  logic                         except_i,
   input  logic [fetch_pkg::ADDR_W-1:0] except_pc_i,
   output logic [fetch_pkg::ADDR_W-1:0] pc_o,
   output logic                         ibus_req_o,
   output logic                         sleep_o
);

   logic [fetch_pkg::ADDR_W-1:0] pc_q;
   logic                         fetch_req_q;
   logic                         busy_q;
   logic                         sleep_q;
   logic                         halt_q;
   logic                         req_w;
   logic                         accept_w;
   logic                         bus_err_w;

   // word taken by decode this cycle
   assign accept_w = insn_ready_i & padv_i & ~except_i & ~sleep_q;

   // error seen on a live request
   assign bus_err_w = ibus_err_i & req_w;

   // an outstanding request (busy) holds until ack or error
   // a fresh one needs padv, and a hit or exception masks it
   assign req_w = ~except_i & ~cache_hit_i &
                  (busy_q | (fetch_req_q & padv_i));

   assign ibus_req_o = req_w;
   assign pc_o       = pc_q;
   assign sleep_o    = sleep_q;

   // program counter
   // a jump to self leaves the pc where it is
   always_ff @(posedge clk)
   begin
      if (rst)
         pc_q <= fetch_pkg::RESET_PC;
      else if (except_i)
         pc_q <= except_pc_i;
      else if (accept_w)
         pc_q <= take_early_i ? early_pc_i : pc_q + fetch_pkg::PC_STEP;
   end

   // completion flag, set while a request waits for its ack
   // hits are masked out of req_w, so ready here means ack
   always_ff @(posedge clk)
   begin
      if (rst)
         busy_q <= 1'b0;
      else
         busy_q <= req_w & ~insn_ready_i & ~ibus_err_i;
   end

   // request state
   // acked while padv is low the word is dropped but still lands in
   // the cache, so the refetch at the same pc is a hit
   always_ff @(posedge clk)
   begin
      if (rst)
         fetch_req_q <= 1'b1;
      else if (except_i)
         fetch_req_q <= 1'b1;
      else if (bus_err_w | halt_q)
         fetch_req_q <= 1'b0;
      else if (sleep_q)
         fetch_req_q <= 1'b0;
      else if (insn_ready_i & will_branch_i)
         // one idle cycle while the pc moves to the target
         fetch_req_q <= 1'b0;
      else if (~padv_i)
         fetch_req_q <= 1'b0;
      else if (cache_hit_i)
         fetch_req_q <= 1'b0;
      else
         fetch_req_q <= 1'b1;
   end

   // bus error halt, only an exception branch restarts fetching
   always_ff @(posedge clk)
   begin
      if (rst)
         halt_q <= 1'b0;
      else if (except_i)
         halt_q <= 1'b0;
      else if (bus_err_w)
         halt_q <= 1'b1;
   end

   // sleep after a jump to self is accepted
   always_ff @(posedge clk)
   begin
      if (rst)
         sleep_q <= 1'b0;
      else if (except_i)
         sleep_q <= 1'b0;
      else if (accept_w & to_self_i)
         sleep_q <= 1'b1;
   end

endmodule

// File: design/fetch_mini_cache.sv
// eight word direct mapped instruction cache with fill, lookup and spr invalidate
`timescale 1ns/1ns

module fetch_mini_cache
(
   input  logic                             clk,
   input  logic                             rst,
   input  logic [fetch_pkg::ADDR_W-1:0]     pc_i,
   input  logic                             fill_i,
   input  logic [fetch_pkg::INSN_W-1:0]     fill_dat_i,
   input  logic [fetch_pkg::SPR_ADDR_W-1:0] spr_addr_i,
   input  logic                             spr_we_i,
   input  logic                             spr_stb_i,
   output logic                             hit_o,
   output logic [fetch_pkg::INSN_W-1:0]     insn_o,
   output logic                             spr_ack_o
);

   // storage, one word and tag per line
   logic [fetch_pkg::INSN_W-1:0]      words [fetch_pkg::CACHE_WORDS];
   logic [fetch_pkg::CACHE_TAG_W-1:0] tags  [fetch_pkg::CACHE_WORDS];
   logic [fetch_pkg::CACHE_WORDS-1:0] valid_q;

   logic [fetch_pkg::CACHE_IDX_W-1:0] idx;
   logic [fetch_pkg::CACHE_TAG_W-1:0] tag;
   logic                              invalidate;

   // word index from pc[4:2], tag from the bits above
   assign idx = pc_i[fetch_pkg::CACHE_IDX_W+1:2];
   assign tag = pc_i[fetch_pkg::ADDR_W-1:fetch_pkg::CACHE_IDX_W+2];

   // lookup is purely combinational on the current pc
   assign hit_o  = valid_q[idx] & (tags[idx] == tag);
   assign insn_o = words[idx];

   // write of any value to icbir flushes all lines
   assign invalidate = spr_stb_i & spr_we_i & (spr_addr_i == fetch_pkg::SPR_ICBIR);

   // valid bits
   // invalidate wins over a fill in the same cycle
   always_ff @(posedge clk)
   begin
      if (rst)
         valid_q <= '0;
      else if (invalidate)
         valid_q <= '0;
      else if (fill_i)
         valid_q[idx] <= 1'b1;
   end

   // word and tag arrays
   always_ff @(posedge clk)
   begin
      if (fill_i)
      begin
         words[idx] <= fill_dat_i;
         tags[idx]  <= tag;
      end
   end

   // spr access completes one cycle after the strobe
   always_ff @(posedge clk)
   begin
      if (rst)
         spr_ack_o <= 1'b0;
      else
         spr_ack_o <= spr_stb_i;
   end

endmodule

// File: design/fetch_predecode.sv
// fetch predecode, classifies the incoming word and computes the early next pc
`timescale 1ns/1ns

module fetch_predecode
(
   input  logic [fetch_pkg::INSN_W-1:0] new_insn_i,
   input  logic                         insn_ready_i,
   input  logic [fetch_pkg::ADDR_W-1:0] pc_i,
   input  logic                         flag_i,
   input  logic                         flag_set_i,
   input  logic                         flag_clear_i,
   output logic                         take_early_o,
   output logic [fetch_pkg::ADDR_W-1:0] early_pc_o,
   output logic                         will_branch_o,
   output logic                         no_rf_read_o,
   output logic                         to_self_o
);

   logic [fetch_pkg::OPC_W-1:0]  opcode;
   logic [fetch_pkg::ADDR_W-1:0] offset;
   logic                         bf_taken;
   logic                         bnf_taken;

   assign opcode = new_insn_i[fetch_pkg::OPC_LSB +: fetch_pkg::OPC_W];

   // word offset, sign extended and scaled to bytes
   assign offset = {{(fetch_pkg::ADDR_W - fetch_pkg::JIMM_W - 2){new_insn_i[fetch_pkg::JIMM_W-1]}},
                    new_insn_i[fetch_pkg::JIMM_W-1:0], 2'b00};

   // target is only meaningful when take_early_o is set
   assign early_pc_o = pc_i + offset;

   // flag as the branch will see it, with a set or clear from
   // the instruction ahead folded in
   assign bf_taken  = (flag_i & ~flag_clear_i) | flag_set_i;
   assign bnf_taken = ~(flag_i | flag_set_i) | flag_clear_i;

   always_comb
   begin
      take_early_o = 1'b0;
      no_rf_read_o = 1'b0;
      if (insn_ready_i)
      begin
         case (opcode)
            fetch_pkg::OPC_J, fetch_pkg::OPC_JAL:
            begin
               take_early_o = 1'b1;
               no_rf_read_o = 1'b1;
            end
            fetch_pkg::OPC_BNF:
            begin
               take_early_o = bnf_taken;
               no_rf_read_o = 1'b1;
            end
            fetch_pkg::OPC_BF:
            begin
               take_early_o = bf_taken;
               no_rf_read_o = 1'b1;
            end
            // everything else flows through as an ordinary word
            default:
            begin
               take_early_o = 1'b0;
               no_rf_read_o = 1'b0;
            end
         endcase
      end
   end

   // every redirect is resolved here, so a branch means a taken early target
   assign will_branch_o = take_early_o;

   // jump to own address puts the stage to sleep
   assign to_self_o = take_early_o & (early_pc_o == pc_i);

endmodule

// File: design/fetch_pkg.sv
// fetch stage package holding widths, reset vector, opcodes and mini cache geometry
package fetch_pkg;

   // datapath widths
   localparam int INSN_W    = 32;
   localparam int ADDR_W    = 32;
   localparam int RF_ADDR_W = 5;
   localparam int OPC_W     = 6;

   // instruction field positions
   localparam int OPC_LSB = 26;
   localparam int JIMM_W  = 26;
   localparam int RFA_LSB = 16;
   localparam int RFB_LSB = 11;

   // first fetch address after reset
   localparam logic [ADDR_W-1:0] RESET_PC = 32'h0000_0100;

   // sequential step of the program counter
   localparam logic [ADDR_W-1:0] PC_STEP = 32'd4;

   // major opcodes, bits 31..26 of the word
   localparam logic [OPC_W-1:0] OPC_J   = 6'h00;
   localparam logic [OPC_W-1:0] OPC_JAL = 6'h01;
   localparam logic [OPC_W-1:0] OPC_BNF = 6'h03;
   localparam logic [OPC_W-1:0] OPC_BF  = 6'h04;
   localparam logic [OPC_W-1:0] OPC_NOP = 6'h05;

   // bubble sent to decode
   localparam logic [INSN_W-1:0] NOP_INSN = {OPC_NOP, 26'd0};

   // mini cache geometry
   // index comes from pc[4:2], the tag is everything above it
   localparam int CACHE_IDX_W = 3;
   localparam int CACHE_WORDS = 8;
   localparam int CACHE_TAG_W = ADDR_W - CACHE_IDX_W - 2;

   // spr bus
   localparam int SPR_ADDR_W = 16;

   // block invalidate register, any write flushes the whole cache
   localparam logic [SPR_ADDR_W-1:0] SPR_ICBIR = 16'h2002;

endpackage
